// ==== hw/cd_link_pkg.sv ====
// Frame layout of the CD link. Both directions share one frame format and the toggle is the MSB
`default_nettype none

package cd_link_pkg;

	////////////////////////////////////////////////////////////////////
	// Frame geometry
	////////////////////////////////////////////////////////////////////

	localparam int CMD_PAYLOAD_W  = 96;   // Full command block
	localparam int DOUT_PAYLOAD_W = 80;   // Data-out block, low part of payload only
	localparam int TAG_W          = 16;
	localparam int FRAME_W        = CMD_PAYLOAD_W + TAG_W + 1;

	// Tags written by the console side
	localparam logic [TAG_W-1:0] TAG_DOUT     = 16'h0001;
	localparam logic [TAG_W-1:0] TAG_DATA_END = 16'h0002;
	localparam logic [TAG_W-1:0] TAG_RESET    = 16'h00FF;

	// One link frame, toggle on top
	typedef struct packed {
		logic                     toggle;
		logic [TAG_W-1:0]         tag;
		logic [CMD_PAYLOAD_W-1:0] payload;
	} cd_frame_t;

	////////////////////////////////////////////////////////////////////
	// Host status frame fields
	////////////////////////////////////////////////////////////////////

	localparam int STAT_W          = 16;  // Status low byte, message high byte
	localparam int STAT_DOUT_BIT   = 16;  // Set means data-out request
	localparam int STAT_REGION_BIT = 17;

	// Sector download header is {dm, length}
	localparam int SECT_LEN_W = 15;

	localparam int CNT_W = 8;   // Frame counters, wrap freely

	typedef logic [7:0] cd_byte_t;

endpackage

`default_nettype wire

// ==== hw/cd_cmd_tx.sv ====
// Console to host framing. Requests are rising-edge detected and same-cycle losers are dropped
`timescale 1ns/100ps
`default_nettype none

module cd_cmd_tx import cd_link_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      cmd_send,
	input  wire [CMD_PAYLOAD_W-1:0]  cmd,
	input  wire                      dout_send,
	input  wire [DOUT_PAYLOAD_W-1:0] dout,
	input  wire                      data_end_req,
	input  wire                      drive_reset_req,
	input  wire                      fast_seek,
	output cd_frame_t                to_host,
	output logic [CNT_W-1:0]         cmd_cnt
);

	// Previous strobe levels
	logic cmd_send_d;
	logic dout_send_d;
	logic data_end_d;
	logic drive_reset_d;

	logic cmd_rise;
	logic dout_rise;
	logic data_end_rise;
	logic drive_reset_rise;

	assign cmd_rise         = cmd_send & ~cmd_send_d;
	assign dout_rise        = dout_send & ~dout_send_d;
	assign data_end_rise    = data_end_req & ~data_end_d;
	assign drive_reset_rise = drive_reset_req & ~drive_reset_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_send_d    <= 1'b0;
			dout_send_d   <= 1'b0;
			data_end_d    <= 1'b0;
			drive_reset_d <= 1'b0;
			to_host       <= cd_frame_t'({FRAME_W{1'b0}});
			cmd_cnt       <= '0;
		end
		else begin
			cmd_send_d    <= cmd_send;
			dout_send_d   <= dout_send;
			data_end_d    <= data_end_req;
			drive_reset_d <= drive_reset_req;

			// Fixed priority, one frame per cycle
			if (cmd_rise) begin
				to_host.payload <= cmd;
				to_host.tag     <= {fast_seek, {(TAG_W-1){1'b0}}};   // Seek mode in tag MSB
				to_host.toggle  <= ~to_host.toggle;
				cmd_cnt         <= cmd_cnt + 1'b1;
			end
			else if (dout_rise) begin
				// Upper payload bits keep the last command
				to_host.payload[DOUT_PAYLOAD_W-1:0] <= dout;
				to_host.tag    <= TAG_DOUT;
				to_host.toggle <= ~to_host.toggle;
			end
			else if (data_end_rise) begin
				to_host.tag    <= TAG_DATA_END;
				to_host.toggle <= ~to_host.toggle;
			end
			else if (drive_reset_rise) begin
				to_host.tag    <= TAG_RESET;   // Tag only
				to_host.toggle <= ~to_host.toggle;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/cd_stat_rx.sv ====
// Host to console status. A frame counts as new only when its toggle differs from the last one
`timescale 1ns/100ps
`default_nettype none

module cd_stat_rx import cd_link_pkg::*; (
	input  wire              clk_sys,
	input  wire              reset,
	input  cd_frame_t        from_host,
	output cd_byte_t         cd_stat,
	output cd_byte_t         cd_msg,
	output logic             region,
	output logic             stat_get,
	output logic             dout_req,
	output logic [CNT_W-1:0] stat_cnt
);

	logic last_toggle;
	logic new_frame;

	assign new_frame = from_host.toggle != last_toggle;

	////////////////////////////////////////////////////////////////////
	// Frame detect and pulses
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_toggle <= 1'b0;
			region      <= 1'b0;
			stat_get    <= 1'b0;
			dout_req    <= 1'b0;
			stat_cnt    <= '0;
		end
		else begin
			stat_get <= 1'b0;   // Single-cycle pulses
			dout_req <= 1'b0;
			if (new_frame) begin
				last_toggle <= from_host.toggle;
				region      <= from_host.payload[STAT_REGION_BIT];
				// Flag picks which pulse the console sees
				stat_get    <= ~from_host.payload[STAT_DOUT_BIT];
				dout_req    <= from_host.payload[STAT_DOUT_BIT];
				stat_cnt    <= stat_cnt + 1'b1;
			end
		end
	end

	// Status word, message in the high byte
	always_ff @(posedge clk_sys) begin
		if (new_frame) begin
			{cd_msg, cd_stat} <= from_host.payload[STAT_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/cd_sector_feed.sv ====
// Sector download to byte stream. No back-pressure, so data words must be at least 4 cycles apart
`timescale 1ns/100ps
`default_nettype none

module cd_sector_feed import cd_link_pkg::*; (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                dl_active,
	input  wire                dl_wr,
	input  wire [SECT_LEN_W:0] dl_data,
	output cd_byte_t           cd_data,
	output logic               cd_wr,
	output logic               cd_dm
);

	logic                  dl_active_d;
	logic                  hdr_seen;    // Header word taken
	logic [SECT_LEN_W-1:0] sect_len;    // Bytes in this download
	logic [SECT_LEN_W-1:0] byte_cnt;    // Bytes already written
	logic [SECT_LEN_W-1:0] byte_cnt_nx;
	logic [SECT_LEN_W:0]   word_q;
	logic                  byte_sel;    // 0 low byte, 1 high byte
	logic                  wr_phase;    // Bytes of word_q still going out

	logic dl_start;
	logic hdr_take;
	logic word_take;

	assign dl_start    = dl_active & ~dl_active_d;
	assign byte_cnt_nx = byte_cnt + 1'b1;

	// Header is the first word after a restart and may share the restart cycle
	assign hdr_take  = dl_wr && dl_active && (!hdr_seen || dl_start);
	assign word_take = dl_wr && dl_active && !hdr_take && (byte_cnt < sect_len);

	assign cd_data = byte_sel ? word_q[15:8] : word_q[7:0];

	////////////////////////////////////////////////////////////////////
	// Parser and write strobe
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			hdr_seen    <= 1'b0;
			sect_len    <= '0;
			byte_cnt    <= '0;
			byte_sel    <= 1'b0;
			wr_phase    <= 1'b0;
			cd_wr       <= 1'b0;
			cd_dm       <= 1'b0;
		end
		else begin
			dl_active_d <= dl_active;

			// Two cycles per byte with strobe high then low
			if (wr_phase) begin
				if (!cd_wr) begin
					cd_wr <= 1'b1;
				end
				else begin
					cd_wr    <= 1'b0;
					byte_sel <= ~byte_sel;
					byte_cnt <= byte_cnt_nx;
					if (byte_sel || byte_cnt_nx >= sect_len) begin
						wr_phase <= 1'b0;   // Word done or length reached
					end
				end
			end

			if (dl_start) begin
				hdr_seen <= 1'b0;
				sect_len <= '0;
				byte_cnt <= '0;
			end

			if (hdr_take) begin
				{cd_dm, sect_len} <= dl_data;
				byte_cnt <= '0;
				hdr_seen <= 1'b1;
			end
			else if (word_take) begin
				wr_phase <= 1'b1;
				byte_sel <= 1'b0;   // Low byte first
			end
		end
	end

	// Data word register
	always_ff @(posedge clk_sys) begin
		if (word_take) begin
			word_q <= dl_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cd_link_top.sv ====
// CD link top level. All ports are in the clk_sys domain, host frames must arrive already synchronized
`timescale 1ns/100ps
`default_nettype none

module cd_link_top import cd_link_pkg::*; (
	input  wire                      clk_sys,
	input  wire                      reset,

	// Console requests
	input  wire                      cmd_send,
	input  wire [CMD_PAYLOAD_W-1:0]  cmd,
	input  wire                      dout_send,
	input  wire [DOUT_PAYLOAD_W-1:0] dout,
	input  wire                      data_end_req,
	input  wire                      drive_reset_req,
	input  wire                      fast_seek,

	// Host link
	output cd_frame_t                to_host,
	input  cd_frame_t                from_host,

	// Status back to the console
	output cd_byte_t                 cd_stat,
	output cd_byte_t                 cd_msg,
	output logic                     region,
	output logic                     stat_get,
	output logic                     dout_req,
	output logic [CNT_W-1:0]         cmd_cnt,
	output logic [CNT_W-1:0]         stat_cnt,

	// Sector download
	input  wire                      dl_active,
	input  wire                      dl_wr,
	input  wire [SECT_LEN_W:0]       dl_data,
	output cd_byte_t                 cd_data,
	output logic                     cd_wr,
	output logic                     cd_dm
);

	cd_cmd_tx u_cmd_tx (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cmd_send        (cmd_send),
		.cmd             (cmd),
		.dout_send       (dout_send),
		.dout            (dout),
		.data_end_req    (data_end_req),
		.drive_reset_req (drive_reset_req),
		.fast_seek       (fast_seek),
		.to_host         (to_host),
		.cmd_cnt         (cmd_cnt)
	);

	cd_stat_rx u_stat_rx (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.from_host (from_host),
		.cd_stat   (cd_stat),
		.cd_msg    (cd_msg),
		.region    (region),
		.stat_get  (stat_get),
		.dout_req  (dout_req),
		.stat_cnt  (stat_cnt)
	);

	// Download words to console bytes
	cd_sector_feed u_sector_feed (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.cd_data   (cd_data),
		.cd_wr     (cd_wr),
		.cd_dm     (cd_dm)
	);

endmodule

`default_nettype wire

// ==== verif/cd_link_assert.sv ====
// Strobe checks on the link top. Assumes host frames are spaced so status pulses never merge
`timescale 1ns/100ps
`default_nettype none

module cd_link_assert (
	input wire clk_sys,
	input wire reset,
	input wire stat_get,
	input wire dout_req,
	input wire cd_wr
);

	int fail_cnt = 0;   // Assertion failures so far

	// Only one pulse kind per host frame
	a_pulse_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(stat_get && dout_req))
		else begin
			$error("stat_get and dout_req high together");
			fail_cnt++;
		end

	a_stat_one: assert property (@(posedge clk_sys) disable iff (reset)
		stat_get |=> !stat_get)
		else begin
			$error("stat_get longer than one cycle");
			fail_cnt++;
		end

	a_dout_one: assert property (@(posedge clk_sys) disable iff (reset)
		dout_req |=> !dout_req)
		else begin
			$error("dout_req longer than one cycle");
			fail_cnt++;
		end

	a_wr_gap: assert property (@(posedge clk_sys) disable iff (reset)
		cd_wr |=> !cd_wr)   // Two cycles per byte
		else begin
			$error("cd_wr high two cycles in a row");
			fail_cnt++;
		end

endmodule

bind cd_link_top cd_link_assert assert_i (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.stat_get (stat_get),
	.dout_req (dout_req),
	.cd_wr    (cd_wr)
);

`default_nettype wire

// ==== verif/cd_link_tb.sv ====
// CD link testbench. Stops at the first mismatch. Download words are spaced six cycles apart
`timescale 1ns/100ps
`default_nettype none

module cd_link_tb import cd_link_pkg::*; ();

	logic clk_sys, reset, cmd_send, dout_send, data_end_req, drive_reset_req, fast_seek;
	logic [CMD_PAYLOAD_W-1:0] cmd;
	logic [DOUT_PAYLOAD_W-1:0] dout;
	logic dl_active, dl_wr;
	logic [SECT_LEN_W:0] dl_data;
	cd_frame_t to_host, from_host, exp_frame;
	cd_byte_t cd_stat, cd_msg, cd_data;
	logic region, stat_get, dout_req, cd_wr, cd_dm;
	logic [CNT_W-1:0] cmd_cnt, stat_cnt, exp_cmd_cnt, exp_stat_cnt;
	logic [3:0] prev_req;   // Request levels of the last cycle with cmd in bit 0
	cd_byte_t exp_bytes[$];
	logic [17:0] exp_stat[$];

	cd_link_top dut_i (.clk_sys(clk_sys), .reset(reset), .cmd_send(cmd_send), .cmd(cmd),
		.dout_send(dout_send), .dout(dout), .data_end_req(data_end_req),
		.drive_reset_req(drive_reset_req), .fast_seek(fast_seek), .to_host(to_host),
		.from_host(from_host), .cd_stat(cd_stat), .cd_msg(cd_msg), .region(region),
		.stat_get(stat_get), .dout_req(dout_req), .cmd_cnt(cmd_cnt), .stat_cnt(stat_cnt),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_data(dl_data), .cd_data(cd_data),
		.cd_wr(cd_wr), .cd_dm(cd_dm));

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////////////////////////

	// Next outgoing frame where only the first rising edge in priority order counts
	function automatic cd_frame_t next_frame(input cd_frame_t cur, input logic [3:0] rise,
		input logic [CMD_PAYLOAD_W-1:0] c, input logic [DOUT_PAYLOAD_W-1:0] d, input logic fs);
		cd_frame_t n;
		n = cur;
		if (rise[0]) begin
			n.payload = c;
			n.tag = {fs, 15'h0};
		end
		else if (rise[1]) begin
			n.payload[DOUT_PAYLOAD_W-1:0] = d;
			n.tag = TAG_DOUT;
		end
		else if (rise[2]) n.tag = TAG_DATA_END;
		else if (rise[3]) n.tag = TAG_RESET;
		if (rise != 4'b0) n.toggle = ~cur.toggle;
		return n;
	endfunction

	// Packed as {region, dout flag, message, status}
	function automatic logic [17:0] stat_expect(input logic [CMD_PAYLOAD_W-1:0] p);
		return {p[STAT_REGION_BIT], p[STAT_DOUT_BIT], p[15:8], p[7:0]};
	endfunction

	function automatic void push_word_bytes(input logic [15:0] w, input int len,
		inout int written);
		if (written < len) begin
			exp_bytes.push_back(w[7:0]);   // Low byte first
			written++;
			if (written < len) begin
				exp_bytes.push_back(w[15:8]);
				written++;
			end
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Comparison processes
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (!reset && cd_wr === 1'b1) begin
			if (exp_bytes.size() == 0) abort_run("Write strobe seen with no byte expected");
			else check("cd_data", exp_bytes.pop_front(), cd_data);
		end
	end

	always @(negedge clk_sys) begin
		logic [17:0] e;
		if (!reset && (stat_get === 1'b1 || dout_req === 1'b1)) begin
			if (exp_stat.size() == 0) abort_run("Status pulse seen with no host frame pending");
			else begin
				e = exp_stat.pop_front();
				check("pulse_kind", {e[16], ~e[16]}, {dout_req, stat_get});
				check("cd_stat", e[7:0], cd_stat);
				check("cd_msg", e[15:8], cd_msg);
				check("region", e[17], region);
			end
		end
	end

	// Bound assertions count their failures
	always @(negedge clk_sys) begin
		if (dut_i.assert_i.fail_cnt != 0)
			abort_run("A bound assertion on the DUT strobes failed");
	end

	task automatic wait_drain(input bit bytes_q);
		int t;
		for (t = 0; t < 500; t++) begin
			if ((bytes_q ? exp_bytes.size() : exp_stat.size()) == 0) break;
			@(negedge clk_sys);
		end
		if ((bytes_q ? exp_bytes.size() : exp_stat.size()) != 0)
			abort_run(bytes_q ? "Timed out waiting for sector bytes"
				: "Timed out waiting for a status pulse");
	endtask

	// One cycle of console requests checked one cycle later
	task automatic step(input logic c, input logic d, input logic e, input logic r);
		logic [3:0] rise;
		logic fs;
		fs = 1'($urandom % 2);
		cmd = {$urandom, $urandom, $urandom};
		dout = DOUT_PAYLOAD_W'({$urandom, $urandom, $urandom});
		{drive_reset_req, data_end_req, dout_send, cmd_send, fast_seek} = {r, e, d, c, fs};
		rise = {r, e, d, c} & ~prev_req;
		prev_req = {r, e, d, c};
		exp_frame = next_frame(exp_frame, rise, cmd, dout, fs);
		if (rise[0]) exp_cmd_cnt++;
		@(negedge clk_sys);
		check("to_host", exp_frame, to_host);
		check("cmd_cnt", exp_cmd_cnt, cmd_cnt);
	endtask

	task automatic send_host(input bit flip);
		cd_frame_t f;
		f.payload = {$urandom, $urandom, $urandom};
		f.tag = TAG_W'($urandom);
		f.toggle = flip ? ~from_host.toggle : from_host.toggle;
		if (flip) begin
			exp_stat.push_back(stat_expect(f.payload));
			exp_stat_cnt++;
		end
		from_host = f;
		@(negedge clk_sys);
		wait_drain(1'b0);
		repeat (2) @(negedge clk_sys);
		check("stat_cnt", exp_stat_cnt, stat_cnt);
	endtask

	task automatic download(input int len, input int nwords);
		logic dm;
		logic [15:0] w;
		int written;
		dm = 1'($urandom % 2);
		written = 0;
		dl_active = 1'b0;
		@(negedge clk_sys);
		dl_active = 1'b1;   // Header in the restart cycle
		dl_wr = 1'b1;
		dl_data = {dm, 15'(len)};
		@(negedge clk_sys);
		dl_wr = 1'b0;
		check("cd_dm", dm, cd_dm);
		for (int i = 0; i < nwords; i++) begin
			repeat (5) @(negedge clk_sys);
			w = 16'($urandom);
			push_word_bytes(w, len, written);
			dl_wr = 1'b1;
			dl_data = w;
			@(negedge clk_sys);
			dl_wr = 1'b0;
		end
		wait_drain(1'b1);
		repeat (8) @(negedge clk_sys);
		dl_active = 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		int len;
		void'($urandom(15));
		{reset, cmd_send, dout_send, data_end_req, drive_reset_req, fast_seek} = 6'b100000;
		{cmd, dout, from_host, exp_frame} = '0;
		{dl_active, dl_wr, dl_data} = '0;
		{exp_cmd_cnt, exp_stat_cnt, prev_req} = '0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		check("reset_to_host", '0, to_host);
		check("reset_counters", '0, {cmd_cnt, stat_cnt});
		repeat (10) @(negedge clk_sys);   // Any pulse here is flagged
		step(1, 0, 0, 0);
		repeat (3) step(1, 0, 0, 0);      // Held high gives no new frame
		step(0, 0, 0, 0);
		step(0, 1, 0, 0);
		step(0, 0, 1, 0);
		step(0, 0, 0, 1);
		step(0, 0, 0, 0);
		step(1, 1, 1, 1);
		step(0, 0, 0, 0);
		step(0, 1, 1, 1);
		step(0, 0, 0, 0);
		step(0, 0, 1, 1);
		repeat (60) step(1'($urandom % 2), 1'($urandom % 2),
			1'($urandom % 2), 1'($urandom % 2));
		repeat (16) send_host(($urandom % 4) != 0);
		repeat (2) begin
			len = 2 * ($urandom % 8) + 5;   // Odd byte count
			download(len, (len + 1) / 2 + 2);
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/cd_link_pkg.sv
hw/cd_cmd_tx.sv
hw/cd_stat_rx.sv
hw/cd_sector_feed.sv
hw/cd_link_top.sv
verif/cd_link_assert.sv
verif/cd_link_tb.sv
